/* sim.f */
+incdir+source
source/fetch_pkg.sv
source/branch_scan.sv
source/branch_predictor.sv
source/next_pc_select.sv
source/fetch_predict_top.sv
verif/tb_fetch_predict.sv

/* Bender.yml */
package:
  name: fetch_predict

sources:
  - include_dirs:
      - source
    files:
      - source/fetch_pkg.sv
      - source/branch_scan.sv
      - source/branch_predictor.sv
      - source/next_pc_select.sv
      - source/fetch_predict_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - verif/tb_fetch_predict.sv

/* verif/tb_fetch_predict.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module tb_fetch_predict;

    localparam int RESET_CYCLES   = 16;
    localparam int NUM_CYCLES     = 2000;
    // Room for reset, the drain and some slack
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 500;

    // Findings of one bundle as seen by the model
    typedef struct {
        logic [15:0] pc;
        logic [3:0]  mask;
        logic        loop;
        logic [15:0] bt;
        logic [15:0] lt;
    } finding_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               fetch_valid;
    logic [15:0]        fetch_pc;
    fetch_pkg::instr_u  bundle [4];
    logic               commit_branch;
    logic               mispredict;
    logic               pred_log;
    logic               pred_valid;
    fetch_pkg::pc_sel_e pc_sel;
    logic [15:0]        next_pc;
    logic               pred_taken;

    // Model state
    fetch_pkg::pred_cnt_e model_cnt;
    finding_t             scan_q [$];
    logic                 exp_valid;
    fetch_pkg::pc_sel_e   exp_sel;
    logic [15:0]          exp_pc;
    int                   cycle_count = 0;

    fetch_predict_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .instr0        (bundle[0]),
        .instr1        (bundle[1]),
        .instr2        (bundle[2]),
        .instr3        (bundle[3]),
        .commit_branch (commit_branch),
        .mispredict    (mispredict),
        .pred_log      (pred_log),
        .pred_valid    (pred_valid),
        .pc_sel        (pc_sel),
        .next_pc       (next_pc),
        .pred_taken    (pred_taken)
    );

    always #20 clk = ~clk;

    // Hang guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run hung, still going after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    // Weighted opcode mix of about 30% branch and 10% loop start
    function automatic fetch_pkg::instr_u random_word();
        fetch_pkg::instr_u w;
        int                roll;
        logic [3:0]        op;
        roll = $urandom_range(99);
        w    = 16'($urandom);
        if (roll < 30) begin
            w.br_fmt.op = `OP_BRANCH;
        end else if (roll < 40) begin
            w.loop_fmt.op = `OP_LOOP;
        end else begin
            // Skip over the two control opcodes
            op = 4'($urandom_range(13));
            if (op >= `OP_BRANCH)
                op = op + 4'd2;
            w.alu_fmt.op = op;
        end
        return w;
    endfunction

    task automatic drive_inputs(input int cycle);
        logic bias;
        // Counter bias flips every 200 cycles to reach both ends
        bias = ((cycle / 200) % 2) == 0;
        fetch_pc = 16'($urandom);
        for (int i = 0; i < 4; i++)
            bundle[i] = random_word();
        if (cycle >= NUM_CYCLES - 4) begin
            // Drain the pipe
            fetch_valid   = 1'b0;
            commit_branch = 1'b0;
            mispredict    = 1'b0;
        end else begin
            fetch_valid   = $urandom_range(99) < 75;
            commit_branch = $urandom_range(99) < 30;
            mispredict    = $urandom_range(99) < 20;
        end
        pred_log = ($urandom_range(99) < 80) ? bias : !bias;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Lowest slot of each kind gives the target
    function automatic finding_t scan_bundle();
        finding_t f;
        int       slot_addr;
        f.pc   = fetch_pc;
        f.mask = '0;
        f.loop = 1'b0;
        f.bt   = '0;
        f.lt   = '0;
        for (int i = 0; i < 4; i++) begin
            slot_addr = int'(fetch_pc) + i;
            if (bundle[i].alu_fmt.op == `OP_BRANCH) begin
                if (f.mask == '0)
                    f.bt = 16'(slot_addr + int'($signed(bundle[i].br_fmt.offset)));
                f.mask[i] = 1'b1;
            end
            if (bundle[i].alu_fmt.op == `OP_LOOP) begin
                if (!f.loop)
                    f.lt = 16'(slot_addr - int'(bundle[i].loop_fmt.offset));
                f.loop = 1'b1;
            end
        end
        return f;
    endfunction

    function automatic fetch_pkg::pred_cnt_e step_model(
        input fetch_pkg::pred_cnt_e cnt,
        input logic                 up
    );
        int n;
        n = up ? int'(cnt) + 1 : int'(cnt) - 1;
        if (n < 0)
            n = 0;
        if (n > 3)
            n = 3;
        return fetch_pkg::pred_cnt_e'(n);
    endfunction

    // One rising edge with the inputs as they stood at that edge
    task automatic model_edge();
        finding_t f;
        int       nbr;
        logic     taken;
        exp_valid = 1'b0;
        exp_sel   = fetch_pkg::SEL_NONE;
        if (scan_q.size() != 0) begin
            f         = scan_q.pop_front();
            nbr       = $countones(f.mask);
            // Counter value before this edge
            taken     = model_cnt >= fetch_pkg::CNT_WT;
            exp_valid = 1'b1;
            if (f.loop) begin
                exp_sel = fetch_pkg::SEL_REDIRECT;
                exp_pc  = f.lt;
            end else if (nbr == 0) begin
                exp_pc = f.pc + 16'd4;
            end else begin
                if (nbr == 1)
                    exp_sel = taken ? fetch_pkg::SEL_ONE : fetch_pkg::SEL_NONE;
                else
                    exp_sel = taken ? fetch_pkg::SEL_REDIRECT : fetch_pkg::SEL_NONE;
                exp_pc = taken ? f.bt : f.pc + 16'd4;
            end
        end
        if (fetch_valid)
            scan_q.push_back(scan_bundle());
        // Commit wins over mispredict
        if (commit_branch)
            model_cnt = step_model(model_cnt, pred_log);
        else if (mispredict)
            model_cnt = step_model(model_cnt, !pred_log);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic [15:0] exp,
                                 input logic [15:0] act);
        assert (act === exp) else begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_outputs();
        compare_value("pred_valid", exp_valid, pred_valid);
        compare_value("pc_sel", exp_sel, pc_sel);
        compare_value("pred_taken", model_cnt >= fetch_pkg::CNT_WT, pred_taken);
        // next_pc only means something with a pulse
        if (exp_valid)
            compare_value("next_pc", exp_pc, next_pc);
    endtask

    initial begin
        void'($urandom(32'h121a));
        rst_n         = 1'b0;
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        commit_branch = 1'b0;
        mispredict    = 1'b0;
        pred_log      = 1'b0;
        for (int i = 0; i < 4; i++)
            bundle[i] = '0;
        model_cnt = fetch_pkg::CNT_WT;
        exp_valid = 1'b0;
        exp_sel   = fetch_pkg::SEL_NONE;
        exp_pc    = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Idle and weakly taken after reset
        check_outputs();

        drive_inputs(0);
        for (int cyc = 1; cyc <= NUM_CYCLES; cyc++) begin
            @(negedge clk);
            model_edge();
            check_outputs();
            drive_inputs(cyc);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* source/fetch_predict_top.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_predict_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_valid,
    input  logic [`PC_W-1:0]   fetch_pc,
    input  fetch_pkg::instr_u  instr0,
    input  fetch_pkg::instr_u  instr1,
    input  fetch_pkg::instr_u  instr2,
    input  fetch_pkg::instr_u  instr3,
    input  logic               commit_branch,
    input  logic               mispredict,
    input  logic               pred_log,
    output logic               pred_valid,
    output fetch_pkg::pc_sel_e pc_sel,
    output logic [`PC_W-1:0]   next_pc,
    output logic               pred_taken
);

    // Decode to result
    logic                    scan_valid;
    logic [`PC_W-1:0]        scan_pc;
    logic [`FETCH_WIDTH-1:0] branch_mask;
    logic                    loop_found;
    logic [`PC_W-1:0]        branch_target;
    logic [`PC_W-1:0]        loop_target;

    ////////////////////////////////////////////////////////////////////////////
    // Decode, execute and result stages
    ////////////////////////////////////////////////////////////////////////////

    branch_scan i_scan (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .instr0        (instr0),
        .instr1        (instr1),
        .instr2        (instr2),
        .instr3        (instr3),
        .scan_valid    (scan_valid),
        .scan_pc       (scan_pc),
        .branch_mask   (branch_mask),
        .loop_found    (loop_found),
        .branch_target (branch_target),
        .loop_target   (loop_target)
    );

    // Counter runs independent of the bundle flow
    branch_predictor i_pred (
        .clk           (clk),
        .rst_n         (rst_n),
        .commit_branch (commit_branch),
        .mispredict    (mispredict),
        .pred_log      (pred_log),
        .pred_taken    (pred_taken)
    );

    next_pc_select i_sel (
        .clk           (clk),
        .rst_n         (rst_n),
        .scan_valid    (scan_valid),
        .scan_pc       (scan_pc),
        .branch_mask   (branch_mask),
        .loop_found    (loop_found),
        .branch_target (branch_target),
        .loop_target   (loop_target),
        .pred_taken    (pred_taken),
        .pred_valid    (pred_valid),
        .pc_sel        (pc_sel),
        .next_pc       (next_pc)
    );

endmodule

/* source/next_pc_select.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module next_pc_select (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    scan_valid,
    input  logic [`PC_W-1:0]        scan_pc,
    input  logic [`FETCH_WIDTH-1:0] branch_mask,
    input  logic                    loop_found,
    input  logic [`PC_W-1:0]        branch_target,
    input  logic [`PC_W-1:0]        loop_target,
    input  logic                    pred_taken,
    output logic                    pred_valid,
    output fetch_pkg::pc_sel_e      pc_sel,
    output logic [`PC_W-1:0]        next_pc
);

    localparam int CNT_W = $clog2(`FETCH_WIDTH + 1);

    logic [CNT_W-1:0]   br_count;
    logic [`PC_W-1:0]   seq_pc;
    fetch_pkg::pc_sel_e sel_d;
    logic [`PC_W-1:0]   pc_d;

    // Branches found in the bundle
    always_comb begin
        br_count = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++)
            br_count = br_count + CNT_W'(branch_mask[i]);
    end

    // Fall-through is the next bundle
    assign seq_pc = scan_pc + `PC_W'(`FETCH_WIDTH);

    ////////////////////////////////////////////////////////////////////////////
    // Select code and fetch address
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_d = fetch_pkg::SEL_NONE;
        pc_d  = seq_pc;
        if (loop_found) begin
            // Loop start overrides the counter
            sel_d = fetch_pkg::SEL_REDIRECT;
            pc_d  = loop_target;
        end else if (br_count == CNT_W'(1)) begin
            sel_d = pred_taken ? fetch_pkg::SEL_ONE : fetch_pkg::SEL_NONE;
            pc_d  = pred_taken ? branch_target : seq_pc;
        end else if (br_count != '0) begin
            // Several branches, one shared guess
            sel_d = pred_taken ? fetch_pkg::SEL_REDIRECT : fetch_pkg::SEL_NONE;
            pc_d  = pred_taken ? branch_target : seq_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
            pc_sel     <= fetch_pkg::SEL_NONE;
        end else begin
            pred_valid <= scan_valid;
            pc_sel     <= scan_valid ? sel_d : fetch_pkg::SEL_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (scan_valid)
            next_pc <= pc_d;
    end

    // No redirect without a prediction
    a_sel_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !pred_valid |-> pc_sel == fetch_pkg::SEL_NONE);

endmodule

/* source/branch_predictor.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module branch_predictor (
    input  logic clk,
    input  logic rst_n,
    input  logic commit_branch,
    input  logic mispredict,
    input  logic pred_log,
    output logic pred_taken
);

    fetch_pkg::pred_cnt_e cnt_q;
    fetch_pkg::pred_cnt_e cnt_d;

    ////////////////////////////////////////////////////////////////////////////
    // Saturating step
    ////////////////////////////////////////////////////////////////////////////

    function automatic fetch_pkg::pred_cnt_e step_cnt(
        input fetch_pkg::pred_cnt_e cnt,
        input logic                 up
    );
        fetch_pkg::pred_cnt_e res;
        res = cnt;
        if (up) begin
            // Stuck at strongly taken
            if (cnt != fetch_pkg::CNT_ST)
                res = fetch_pkg::pred_cnt_e'(cnt + 2'd1);
        end else begin
            // Stuck at strongly not taken
            if (cnt != fetch_pkg::CNT_SN)
                res = fetch_pkg::pred_cnt_e'(cnt - 2'd1);
        end
        return res;
    endfunction

    // Commit trains toward the logged guess, mispredict pushes away
    always_comb begin
        cnt_d = cnt_q;
        if (commit_branch)
            cnt_d = step_cnt(cnt_q, pred_log);
        else if (mispredict)
            cnt_d = step_cnt(cnt_q, !pred_log);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cnt_q <= fetch_pkg::pred_cnt_e'(`CNT_RESET);
        else
            cnt_q <= cnt_d;
    end

    // Upper half of the range means taken
    assign pred_taken = cnt_q[1];

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Never skips a state
    a_one_step: assert property (@(posedge clk) disable iff (!rst_n)
        (int'(cnt_q) - int'($past(cnt_q))) inside {-1, 0, 1});

    // Idle strobes hold the counter
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !commit_branch && !mispredict |=> $stable(cnt_q));

endmodule

/* source/branch_scan.sv */
`timescale 1ns/1ns
`include "fetch_params.svh"

module branch_scan (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_valid,
    input  logic [`PC_W-1:0]        fetch_pc,
    input  fetch_pkg::instr_u       instr0,
    input  fetch_pkg::instr_u       instr1,
    input  fetch_pkg::instr_u       instr2,
    input  fetch_pkg::instr_u       instr3,
    output logic                    scan_valid,
    output logic [`PC_W-1:0]        scan_pc,
    output logic [`FETCH_WIDTH-1:0] branch_mask,
    output logic                    loop_found,
    output logic [`PC_W-1:0]        branch_target,
    output logic [`PC_W-1:0]        loop_target
);

    // Bundle as an indexable array
    fetch_pkg::instr_u       words    [`FETCH_WIDTH];
    logic [`PC_W-1:0]        slot_pc  [`FETCH_WIDTH];
    logic [`PC_W-1:0]        br_tgt   [`FETCH_WIDTH];
    logic [`PC_W-1:0]        loop_tgt [`FETCH_WIDTH];
    logic [`FETCH_WIDTH-1:0] is_br;
    logic [`FETCH_WIDTH-1:0] is_loop;
    logic [`PC_W-1:0]        br_tgt_sel;
    logic [`PC_W-1:0]        loop_tgt_sel;

    assign words[0] = instr0;
    assign words[1] = instr1;
    assign words[2] = instr2;
    assign words[3] = instr3;

    ////////////////////////////////////////////////////////////////////////////
    // Per-slot decode
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : g_slot
        // Word address within the bundle
        assign slot_pc[i] = fetch_pc + `PC_W'(i);

        // Opcode field is common to every view
        assign is_br[i]   = (words[i].alu_fmt.op == `OP_BRANCH);
        assign is_loop[i] = (words[i].alu_fmt.op == `OP_LOOP);

        // Sign-extended branch offset wraps at 2^16
        assign br_tgt[i] = slot_pc[i]
                         + {{(`PC_W - 12){words[i].br_fmt.offset[11]}},
                            words[i].br_fmt.offset};

        // Loop body lies behind the loop start
        assign loop_tgt[i] = slot_pc[i] - {{(`PC_W - 8){1'b0}}, words[i].loop_fmt.offset};
    end

    // Lowest slot of each kind wins
    always_comb begin
        br_tgt_sel   = br_tgt[0];
        loop_tgt_sel = loop_tgt[0];
        for (int i = `FETCH_WIDTH - 1; i >= 0; i--) begin
            if (is_br[i])
                br_tgt_sel = br_tgt[i];
            if (is_loop[i])
                loop_tgt_sel = loop_tgt[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode stage registers
    ////////////////////////////////////////////////////////////////////////////

    // Findings cleared on idle cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scan_valid  <= 1'b0;
            branch_mask <= '0;
            loop_found  <= 1'b0;
        end else begin
            scan_valid  <= fetch_valid;
            branch_mask <= fetch_valid ? is_br : '0;
            loop_found  <= fetch_valid & (|is_loop);
        end
    end

    // Addresses only captured with a bundle
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            scan_pc       <= fetch_pc;
            branch_target <= br_tgt_sel;
            loop_target   <= loop_tgt_sel;
        end
    end

    // No findings reach the result stage without a valid bundle
    a_idle_clears: assert property (@(posedge clk) disable iff (!rst_n)
        !scan_valid |-> branch_mask == '0 && !loop_found);

endmodule

/* source/fetch_pkg.sv */
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////////////////////

    // Register ALU format
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] rt;
    } alu_fmt_t;

    // Conditional branch, signed word offset from its own slot
    typedef struct packed {
        logic [3:0]         op;
        logic signed [11:0] offset;
    } br_fmt_t;

    // Loop start, offset always counts backward
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] count;
        logic [7:0] offset;
    } loop_fmt_t;

    // One 16-bit word, decoded by opcode
    typedef union packed {
        alu_fmt_t  alu_fmt;
        br_fmt_t   br_fmt;
        loop_fmt_t loop_fmt;
    } instr_u;

    ////////////////////////////////////////////////////////////////////////////
    // Predictor state and fetch redirect code
    ////////////////////////////////////////////////////////////////////////////

    // Ordered so the MSB is the taken bit
    typedef enum logic [1:0] {
        CNT_SN = 2'b00,
        CNT_WN = 2'b01,
        CNT_WT = 2'b10,
        CNT_ST = 2'b11
    } pred_cnt_e;

    typedef enum logic [1:0] {
        SEL_NONE     = 2'b00,
        SEL_ONE      = 2'b10,
        SEL_REDIRECT = 2'b11
    } pc_sel_e;

endpackage

/* source/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Instruction words per fetch bundle
`define FETCH_WIDTH 4

// Address and instruction word width
`define PC_W 16

// Opcodes sit in the top nibble of every word
`define OP_BRANCH 4'hC
`define OP_LOOP 4'hD

// Counter comes out of reset weakly taken
`define CNT_RESET 2'b10

`endif
